/* design/alu.sv */
// Combinational integer ALU for the RV32I operations.
module alu
  import rv32i_isa_pkg::*;
  import core_ctrl_pkg::*;
(
  input  alu_op_t alu_op,
  input  word_t   port_a,
  input  word_t   port_b,
  output word_t   port_out
);

  logic [4:0] shamt;

  // Shifts use only the low five bits of the second operand.
  assign shamt = port_b[4:0];

  always_comb begin
    case (alu_op)
      ADD:     port_out = port_a + port_b;
      SUB:     port_out = port_a - port_b;
      SLL:     port_out = port_a << shamt;
      // Set-less-than yields 0 or 1 in the low bit.
      SLT:     port_out = {31'b0, ($signed(port_a) < $signed(port_b))};
      SLTU:    port_out = {31'b0, (port_a < port_b)};
      XOR:     port_out = port_a ^ port_b;
      SRL:     port_out = port_a >> shamt;
      // The signed operand makes the shift fill with the sign bit.
      SRA:     port_out = $signed(port_a) >>> shamt;
      OR:      port_out = port_a | port_b;
      AND:     port_out = port_a & port_b;
      default: port_out = '0;
    endcase
  end

endmodule

/* design/control_unit.sv */
// Instruction decoder producing datapath controls and the extended immediate.
module control_unit
  import rv32i_isa_pkg::*;
  import core_ctrl_pkg::*;
(
  input  rv32i_instr_u instr,
  output alu_op_t      alu_op,
  output alu_a_sel_t   alu_a_sel,
  output alu_b_sel_t   alu_b_sel,
  output w_sel_t       w_sel,
  output logic         wen,
  output logic         dren,
  output logic         dwen,
  output mem_size_t    mem_size,
  output logic         branch,
  output branch_type_t branch_type,
  output logic         jump,
  output logic         jalr,
  output logic         halt,
  output word_t        imm
);

  // Maps funct3 to an ALU operation. The alt flag picks SUB or SRA.
  function automatic alu_op_t f3_alu_op(input logic [2:0] f3, input logic alt);
    alu_op_t op;
    case (alu_funct3_t'(f3))
      F3_ADD:  op = alt ? SUB : ADD;
      F3_SLL:  op = SLL;
      F3_SLT:  op = SLT;
      F3_SLTU: op = SLTU;
      F3_XOR:  op = XOR;
      F3_SR:   op = alt ? SRA : SRL;
      F3_OR:   op = OR;
      default: op = AND;
    endcase
    return op;
  endfunction

  // Width encodings without a defined meaning fall back to a word access.
  function automatic mem_size_t mem_size_of(input logic [2:0] f3);
    mem_size_t sz;
    case (load_store_funct3_t'(f3))
      F3_B:    sz = MEM_B;
      F3_H:    sz = MEM_H;
      F3_BU:   sz = MEM_BU;
      F3_HU:   sz = MEM_HU;
      default: sz = MEM_W;
    endcase
    return sz;
  endfunction

  always_comb begin
    // Anything not matched below leaves the machine state untouched.
    alu_op      = ADD;
    alu_a_sel   = A_RS1;
    alu_b_sel   = B_RS2;
    w_sel       = W_ALU;
    wen         = 1'b0;
    dren        = 1'b0;
    dwen        = 1'b0;
    mem_size    = MEM_W;
    branch      = 1'b0;
    branch_type = BEQ;
    jump        = 1'b0;
    jalr        = 1'b0;
    halt        = 1'b0;
    imm         = '0;

    case (instr.r_type.opcode)
      LUI, AUIPC: begin
        // LUI adds to x0 and AUIPC adds to the PC.
        wen       = 1'b1;
        alu_a_sel = (instr.u_type.opcode == AUIPC) ? A_PC : A_RS1;
        alu_b_sel = B_IMM;
        imm       = {instr.u_type.imm31_12, 12'b0};
      end
      JAL: begin
        // The ALU forms pc + offset and rd gets the return address.
        wen       = 1'b1;
        jump      = 1'b1;
        w_sel     = W_PC4;
        alu_a_sel = A_PC;
        alu_b_sel = B_IMM;
        imm       = {{11{instr.j_type.imm20}}, instr.j_type.imm20, instr.j_type.imm19_12,
                     instr.j_type.imm11, instr.j_type.imm10_1, 1'b0};
      end
      JALR: begin
        wen       = 1'b1;
        jump      = 1'b1;
        jalr      = 1'b1;
        w_sel     = W_PC4;
        alu_b_sel = B_IMM;
        imm       = {{20{instr.i_type.imm11_0[11]}}, instr.i_type.imm11_0};
      end
      BRANCH: begin
        // The ALU computes the target and the comparison runs beside it.
        branch    = 1'b1;
        alu_a_sel = A_PC;
        alu_b_sel = B_IMM;
        imm       = {{19{instr.b_type.imm12}}, instr.b_type.imm12, instr.b_type.imm11,
                     instr.b_type.imm10_5, instr.b_type.imm4_1, 1'b0};
        case (branch_funct3_t'(instr.b_type.funct3))
          F3_BEQ:  branch_type = BEQ;
          F3_BNE:  branch_type = BNE;
          F3_BLT:  branch_type = BLT;
          F3_BGE:  branch_type = BGE;
          F3_BLTU: branch_type = BLTU;
          F3_BGEU: branch_type = BGEU;
          default: branch = 1'b0;
        endcase
      end
      LOAD: begin
        wen       = 1'b1;
        dren      = 1'b1;
        w_sel     = W_LOAD;
        alu_b_sel = B_IMM;
        mem_size  = mem_size_of(instr.i_type.funct3);
        imm       = {{20{instr.i_type.imm11_0[11]}}, instr.i_type.imm11_0};
      end
      STORE: begin
        dwen      = 1'b1;
        alu_b_sel = B_IMM;
        mem_size  = mem_size_of(instr.s_type.funct3);
        imm       = {{20{instr.s_type.imm11_5[6]}}, instr.s_type.imm11_5,
                     instr.s_type.imm4_0};
      end
      OP_IMM: begin
        // Bit 30 only selects SRAI. For ADDI it is an ordinary immediate bit.
        wen       = 1'b1;
        alu_b_sel = B_IMM;
        alu_op    = f3_alu_op(instr.i_type.funct3,
                              (instr.i_type.funct3 == F3_SR) && instr.r_type.funct7[5]);
        imm       = {{20{instr.i_type.imm11_0[11]}}, instr.i_type.imm11_0};
      end
      OP: begin
        wen    = 1'b1;
        alu_op = f3_alu_op(instr.r_type.funct3, instr.r_type.funct7[5]);
      end
      SYSTEM: begin
        // Only ECALL is recognised, and it stops the core.
        halt = (instr.i_type.funct3 == 3'b000) && (instr.i_type.imm11_0 == 12'h000);
      end
      default: begin
      end
    endcase
  end

endmodule

/* design/core_ctrl_pkg.sv */
// Control encodings passed from the decoder to the execute datapath.
package core_ctrl_pkg;

  // ALU operations.
  typedef enum logic [3:0] {ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND} alu_op_t;

  // First ALU operand is a register or the instruction address.
  typedef enum logic {A_RS1, A_PC} alu_a_sel_t;

  // Second ALU operand is a register or the decoded immediate.
  typedef enum logic {B_RS2, B_IMM} alu_b_sel_t;

  // Source of the value written back to rd.
  typedef enum logic [1:0] {W_LOAD, W_PC4, W_ALU} w_sel_t;

  // Access size in bits 1:0 with the unsigned flag in bit 2.
  typedef enum logic [2:0] {
    MEM_B  = 3'b000,
    MEM_H  = 3'b001,
    MEM_W  = 3'b010,
    MEM_BU = 3'b100,
    MEM_HU = 3'b101
  } mem_size_t;

  // Branch conditions.
  typedef enum logic [2:0] {BEQ, BNE, BLT, BGE, BLTU, BGEU} branch_type_t;

endpackage

/* design/execute_stage.sv */
// Execute stage with decode, register read, ALU, branch resolution, data port
// and write-back.
module execute_stage
  import rv32i_isa_pkg::*;
  import core_ctrl_pkg::*;
(
  input  logic         CLK,
  input  logic         rst,
  input  rv32i_instr_u fe_instr,
  input  word_t        fe_pc,
  input  logic         fe_valid,
  output logic         redirect,
  output word_t        redirect_addr,
  output logic         mem_stall,
  output logic         halt_req,
  output logic         dmem_ren,
  output logic         dmem_wen,
  output word_t        dmem_addr,
  output word_t        dmem_wdata,
  output logic [3:0]   dmem_byte_en,
  input  word_t        dmem_rdata,
  input  logic         dmem_busy
);

  alu_op_t      alu_op;
  alu_a_sel_t   alu_a_sel;
  alu_b_sel_t   alu_b_sel;
  w_sel_t       w_sel;
  mem_size_t    mem_size;
  branch_type_t branch_type;
  logic         cu_wen, cu_dren, cu_dwen, cu_branch, cu_jump, cu_jalr, cu_halt;
  word_t        imm, rs1_data, rs2_data, port_a, port_b, alu_out;
  word_t        lane_data, load_data, w_data;
  logic [4:0]   rs1_addr;
  logic [1:0]   byte_off;
  logic [3:0]   byte_en;
  logic         branch_taken, rf_wen;

  control_unit cu (
    .instr(fe_instr), .alu_op(alu_op), .alu_a_sel(alu_a_sel), .alu_b_sel(alu_b_sel),
    .w_sel(w_sel), .wen(cu_wen), .dren(cu_dren), .dwen(cu_dwen), .mem_size(mem_size),
    .branch(cu_branch), .branch_type(branch_type), .jump(cu_jump), .jalr(cu_jalr),
    .halt(cu_halt), .imm(imm)
  );

  // LUI has no rs1 field. Reading x0 turns the ALU add into a pass of the immediate.
  assign rs1_addr = (fe_instr.u_type.opcode == LUI) ? 5'd0 : fe_instr.r_type.rs1;

  rv32i_reg_file rf (
    .CLK(CLK), .rst(rst), .rs1_addr(rs1_addr), .rs2_addr(fe_instr.r_type.rs2),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .w_addr(fe_instr.r_type.rd),
    .w_data(w_data), .wen(rf_wen)
  );

  assign port_a = (alu_a_sel == A_PC) ? fe_pc : rs1_data;
  assign port_b = (alu_b_sel == B_IMM) ? imm : rs2_data;

  alu alu_unit (.alu_op(alu_op), .port_a(port_a), .port_b(port_b), .port_out(alu_out));

  // Branch condition on the two source registers.
  always_comb begin
    case (branch_type)
      BEQ:     branch_taken = (rs1_data == rs2_data);
      BNE:     branch_taken = (rs1_data != rs2_data);
      BLT:     branch_taken = ($signed(rs1_data) < $signed(rs2_data));
      BGE:     branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
      BLTU:    branch_taken = (rs1_data < rs2_data);
      default: branch_taken = (rs1_data >= rs2_data);
    endcase
  end

  // Fetch always predicts fall-through, so every taken transfer redirects.
  // The ALU has already formed the target, and JALR drops its low bit.
  assign redirect      = fe_valid & (cu_jump | (cu_branch & branch_taken));
  assign redirect_addr = cu_jalr ? {alu_out[31:1], 1'b0} : alu_out;

  // A bubble makes no memory request.
  assign dmem_ren  = fe_valid & cu_dren;
  assign dmem_wen  = fe_valid & cu_dwen;
  assign dmem_addr = alu_out;
  assign byte_off  = alu_out[1:0];

  // Store data goes to every lane and the enables pick the addressed ones.
  always_comb begin
    case (mem_size)
      MEM_B, MEM_BU: begin
        byte_en    = 4'b0001 << byte_off;
        dmem_wdata = {4{rs2_data[7:0]}};
      end
      MEM_H, MEM_HU: begin
        byte_en    = byte_off[1] ? 4'b1100 : 4'b0011;
        dmem_wdata = {2{rs2_data[15:0]}};
      end
      default: begin
        byte_en    = 4'b1111;
        dmem_wdata = rs2_data;
      end
    endcase
  end

  assign dmem_byte_en = (dmem_ren | dmem_wen) ? byte_en : 4'b0000;

  // The pipe freezes for as long as memory holds off the access.
  assign mem_stall = (dmem_ren | dmem_wen) & dmem_busy;

  // Move the addressed lane down to bit 0 and then extend it.
  assign lane_data = dmem_rdata >> {byte_off, 3'b000};

  always_comb begin
    case (mem_size)
      MEM_B:   load_data = {{24{lane_data[7]}}, lane_data[7:0]};
      MEM_BU:  load_data = {24'b0, lane_data[7:0]};
      MEM_H:   load_data = {{16{lane_data[15]}}, lane_data[15:0]};
      MEM_HU:  load_data = {16'b0, lane_data[15:0]};
      default: load_data = lane_data;
    endcase
  end

  always_comb begin
    case (w_sel)
      W_LOAD:  w_data = load_data;
      W_PC4:   w_data = fe_pc + 32'd4;
      default: w_data = alu_out;
    endcase
  end

  // A stalled load writes only in the cycle its data arrives.
  assign rf_wen   = fe_valid & cu_wen & ~mem_stall;
  assign halt_req = fe_valid & cu_halt;

endmodule

/* design/fetch_stage.sv */
// Program counter, fetch/execute register and the sticky halt flag.
module fetch_stage
  import rv32i_isa_pkg::*;
#(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic         CLK,
  input  logic         rst,
  output word_t        imem_addr,
  input  word_t        imem_rdata,
  input  logic         redirect,
  input  word_t        redirect_addr,
  input  logic         mem_stall,
  input  logic         halt_req,
  output rv32i_instr_u fe_instr,
  output word_t        fe_pc,
  output logic         fe_valid,
  output logic         halt
);

  word_t pc;
  logic  advance;
  logic  bubble;

  // Instruction memory answers in the same cycle.
  assign imem_addr = pc;

  // Nothing moves during a memory stall or once the core has halted.
  assign advance = ~mem_stall & ~halt;

  // The word fetched behind a taken transfer or an ECALL is squashed.
  assign bubble = redirect | halt_req;

  always_ff @(posedge CLK) begin
    if (rst) begin
      pc       <= RESET_PC;
      fe_valid <= 1'b0;
      halt     <= 1'b0;
    end else if (advance) begin
      fe_valid <= ~bubble;
      if (halt_req) begin
        // The PC stays on the word after ECALL from here on.
        halt <= 1'b1;
      end else begin
        pc <= redirect ? redirect_addr : pc + 32'd4;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (advance) begin
      fe_instr <= bubble ? NOP_INSTR : rv32i_instr_u'(imem_rdata);
      fe_pc    <= pc;
    end
  end

endmodule

/* design/rv32_core.sv */
// Two-stage RV32I core joining fetch and execute to the memory ports.
module rv32_core
  import rv32i_isa_pkg::*;
#(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic       CLK,
  input  logic       rst,
  output word_t      imem_addr,
  input  word_t      imem_rdata,
  output logic       dmem_ren,
  output logic       dmem_wen,
  output word_t      dmem_addr,
  output word_t      dmem_wdata,
  output logic [3:0] dmem_byte_en,
  input  word_t      dmem_rdata,
  input  logic       dmem_busy,
  output logic       halt
);

  rv32i_instr_u fe_instr;
  word_t        fe_pc;
  word_t        redirect_addr;
  logic         fe_valid, redirect, mem_stall, halt_req;

  fetch_stage #(.RESET_PC(RESET_PC)) fetch (
    .CLK(CLK), .rst(rst), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
    .redirect(redirect), .redirect_addr(redirect_addr), .mem_stall(mem_stall),
    .halt_req(halt_req), .fe_instr(fe_instr), .fe_pc(fe_pc), .fe_valid(fe_valid),
    .halt(halt)
  );

  // Execute owns the data port and feeds redirects and stalls back to fetch.
  execute_stage execute (
    .CLK(CLK), .rst(rst), .fe_instr(fe_instr), .fe_pc(fe_pc), .fe_valid(fe_valid),
    .redirect(redirect), .redirect_addr(redirect_addr), .mem_stall(mem_stall),
    .halt_req(halt_req), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_byte_en(dmem_byte_en),
    .dmem_rdata(dmem_rdata), .dmem_busy(dmem_busy)
  );

endmodule

/* design/rv32i_isa_pkg.sv */
// Word type, major opcodes, funct3 codes and the instruction format union of RV32I.
package rv32i_isa_pkg;

  // One data or address word.
  typedef logic [31:0] word_t;

  // Major opcodes in bits 6:0 of every instruction.
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    SYSTEM = 7'b1110011
  } opcode_t;

  // Condition field of the conditional branches.
  typedef enum logic [2:0] {
    F3_BEQ  = 3'b000,
    F3_BNE  = 3'b001,
    F3_BLT  = 3'b100,
    F3_BGE  = 3'b101,
    F3_BLTU = 3'b110,
    F3_BGEU = 3'b111
  } branch_funct3_t;

  // Access width and signedness of loads and stores.
  typedef enum logic [2:0] {
    F3_B  = 3'b000,
    F3_H  = 3'b001,
    F3_W  = 3'b010,
    F3_BU = 3'b100,
    F3_HU = 3'b101
  } load_store_funct3_t;

  // Operation field shared by OP and OP_IMM.
  // F3_SR covers both logical and arithmetic right shifts.
  typedef enum logic [2:0] {
    F3_ADD  = 3'b000,
    F3_SLL  = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,
    F3_XOR  = 3'b100,
    F3_SR   = 3'b101,
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } alu_funct3_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm4_0;
    opcode_t    opcode;
  } s_type_t;

  // Branch offsets are scattered so that the sign bit always sits in bit 31.
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    opcode_t    opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    opcode_t     opcode;
  } u_type_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    opcode_t    opcode;
  } j_type_t;

  // The same instruction word seen through each of the six formats.
  typedef union packed {
    r_type_t r_type;
    i_type_t i_type;
    s_type_t s_type;
    b_type_t b_type;
    u_type_t u_type;
    j_type_t j_type;
  } rv32i_instr_u;

  // ADDI x0, x0, 0 fills the pipeline slot of a squashed instruction.
  localparam rv32i_instr_u NOP_INSTR = 32'h0000_0013;

endpackage

/* design/rv32i_reg_file.sv */
// Integer register file with two read ports and one write port.
module rv32i_reg_file
  import rv32i_isa_pkg::*;
(
  input  logic       CLK,
  input  logic       rst,
  input  logic [4:0] rs1_addr,
  input  logic [4:0] rs2_addr,
  output word_t      rs1_data,
  output word_t      rs2_data,
  input  logic [4:0] w_addr,
  input  word_t      w_data,
  input  logic       wen
);

  word_t regs [32];

  // Writes to x0 are dropped, so it keeps the zero loaded at reset.
  always_ff @(posedge CLK) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (w_addr != 5'd0)) begin
      regs[w_addr] <= w_data;
    end
  end

  // Reads are combinational and see the old value during a write.
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

endmodule

/* filelist.f */
design/rv32i_isa_pkg.sv
design/core_ctrl_pkg.sv
design/control_unit.sv
design/rv32i_reg_file.sv
design/alu.sv
design/execute_stage.sv
design/fetch_stage.sv
design/rv32_core.sv
tests/core_assertions.sv
tests/core_tb.sv

/* tests/core_assertions.sv */
// Concurrent checks on the data port handshake and on the sticky halt flag.
module core_assertions
  import rv32i_isa_pkg::*;
(
  input logic       CLK,
  input logic       rst,
  input logic       dmem_ren,
  input logic       dmem_wen,
  input word_t      dmem_addr,
  input word_t      dmem_wdata,
  input logic [3:0] dmem_byte_en,
  input logic       dmem_busy,
  input logic       halt
);
  timeunit 1ns;
  timeprecision 100ps;

  // Loads and stores share the port one at a time.
  one_request_a: assert property (@(posedge CLK) disable iff (rst)
    !(dmem_ren && dmem_wen))
    else $error("dmem_ren and dmem_wen high in the same cycle");

  // A request that meets busy stays put until memory takes it.
  hold_request_a: assert property (@(posedge CLK) disable iff (rst)
    (dmem_ren || dmem_wen) && dmem_busy |=>
      $stable(dmem_ren) && $stable(dmem_wen) && $stable(dmem_addr) &&
      $stable(dmem_wdata) && $stable(dmem_byte_en))
    else $error("data port request changed while busy was high");

  halt_sticky_a: assert property (@(posedge CLK) disable iff (rst) halt |=> halt)
    else $error("halt dropped after it was raised");

  // The first cycle out of reset holds a bubble.
  quiet_after_reset_a: assert property (@(posedge CLK)
    $fell(rst) |-> !dmem_ren && !dmem_wen && !halt)
    else $error("request or halt active in the first cycle after reset");

endmodule

bind rv32_core core_assertions core_assertions_i (.*);

/* tests/core_input.txt */
# Records: I addr instr | D addr word | W addr wdata byte_en | H ends the file.
# All values are hex. W records list the expected stores in program order.
D 00000180 80f17fa5
# ALU, immediate, LUI and AUIPC results stored from 0x100 upward.
I 00000000 10000093
I 00000004 80000137
I 00000008 ffb00193
I 0000000c 40218233
I 00000010 0040a023
I 00000014 40415293
I 00000018 0050a223
I 0000001c 00315333
I 00000020 0060a423
I 00000024 0061a3b3
I 00000028 0061b433
I 0000002c 0070a623
I 00000030 0080a823
I 00000034 0f01c493
I 00000038 7f34f513
I 0000003c 006565b3
I 00000040 0090aa23
I 00000044 00b0ac23
I 00000048 00819613
I 0000004c 00001697
I 00000050 00c0ae23
I 00000054 02d0a023
# Branches: a not-taken one aiming at the trap at 0xe8, then a taken one over a poison store.
I 00000058 08838863
I 0000005c 00738463
I 00000060 00002023
I 00000064 08739263
I 00000068 00839463
I 0000006c 00002023
I 00000070 06334c63
I 00000074 0061c463
I 00000078 00002023
I 0000007c 0661d663
I 00000080 00335463
I 00000084 00002023
I 00000088 0661e063
I 0000008c 00336463
I 00000090 00002023
I 00000094 04337a63
I 00000098 0061f463
I 0000009c 00002023
# JAL and JALR skip poison stores and their link values are stored.
I 000000a0 00800aef
I 000000a4 00002023
I 000000a8 0b400b93
I 000000ac 001b8b67
I 000000b0 00002023
I 000000b4 0350a223
I 000000b8 0360a423
# Sub-word loads from 0x180, then SB and SH.
I 000000bc 08008703
I 000000c0 0830c783
I 000000c4 08209803
I 000000c8 0800d883
I 000000cc 02e0a623
I 000000d0 02f0a823
I 000000d4 0300aa23
I 000000d8 0310ac23
I 000000dc 043080a3
I 000000e0 05009323
I 000000e4 00000073
I 000000e8 00002023
I 000000ec 00000073
W 00000100 7ffffffb f
W 00000104 f8000000 f
W 00000108 00000010 f
W 0000010c 00000001 f
W 00000110 00000000 f
W 00000114 ffffff0b f
W 00000118 00000713 f
W 0000011c fffffb00 f
W 00000120 0000104c f
W 00000124 000000a4 f
W 00000128 000000b0 f
W 0000012c ffffffa5 f
W 00000130 00000080 f
W 00000134 ffff80f1 f
W 00000138 00007fa5 f
W 00000141 fbfbfbfb 2
W 00000146 80f180f1 c
H

/* tests/core_tb.sv */
// Testbench for the two-stage RV32I core with instruction and data memory models,
// random busy stretches on the data port, in-order store checks and the halt wait.
module core_tb
  import rv32i_isa_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALT_TIMEOUT = 4000;

  logic        CLK = 1'b0;
  logic        rst;
  word_t       imem_addr;
  word_t       imem_rdata;
  logic        dmem_ren;
  logic        dmem_wen;
  word_t       dmem_addr;
  word_t       dmem_wdata;
  logic [3:0]  dmem_byte_en;
  word_t       dmem_rdata;
  logic        dmem_busy;
  logic        halt;

  // Instruction and data memories of 1 KiB each, indexed by word.
  word_t       imem [256];
  word_t       dmem [256];

  // Expected stores in program order.
  word_t       exp_addr [$];
  word_t       exp_data [$];
  logic [3:0]  exp_be [$];

  int          errors = 0;
  int          checks = 0;
  int          store_count = 0;
  logic [31:0] lcg_state = 32'h8c1d_ddc0;
  logic        in_request = 1'b0;
  logic        done_now;
  int          stretch = 0;

  rv32_core #(.RESET_PC(32'h0000_0000)) dut_i (
    .CLK(CLK), .rst(rst), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
    .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata), .dmem_byte_en(dmem_byte_en), .dmem_rdata(dmem_rdata),
    .dmem_busy(dmem_busy), .halt(halt)
  );

  always #4 CLK = ~CLK;

  // Instruction memory answers without delay. Address bits above 9 wrap.
  assign imem_rdata = imem[imem_addr[9:2]];

  // Read data is only valid in the cycle a read request completes.
  assign dmem_rdata = (dmem_ren && !dmem_busy) ? dmem[dmem_addr[9:2]] : 32'hxxxx_xxxx;

  // Linear congruential step for the busy stretches.
  function automatic logic [31:0] next_random(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Each new request draws a stretch of 0 to 3 busy cycles.
  // The access completes at the first edge where busy is low.
  always @(posedge CLK) begin
    done_now = (dmem_ren || dmem_wen) && !dmem_busy;
    #1;
    if (done_now) begin
      in_request = 1'b0;
    end
    if ((dmem_ren || dmem_wen) && !in_request) begin
      lcg_state  = next_random(lcg_state);
      stretch    = lcg_state[17:16];
      in_request = 1'b1;
    end
    if (in_request && stretch != 0) begin
      dmem_busy = 1'b1;
      stretch--;
    end else begin
      dmem_busy = 1'b0;
    end
  end

  // Every completed store is compared against the next expected entry.
  always @(posedge CLK) begin
    if (!rst && dmem_wen && !dmem_busy) begin
      if (halt) begin
        $display("store to %h completed after halt at %0t", dmem_addr, $time);
        errors++;
      end
      if (store_count >= exp_addr.size()) begin
        $display("extra store to %h at %0t beyond the expected sequence", dmem_addr, $time);
        errors++;
      end else begin
        checks += 3;
        if (dmem_addr !== exp_addr[store_count]) begin
          $display("mismatch at %0t: dmem_addr expected %h got %h",
                   $time, exp_addr[store_count], dmem_addr);
          errors++;
        end
        if (dmem_wdata !== exp_data[store_count]) begin
          $display("mismatch at %0t: dmem_wdata expected %h got %h",
                   $time, exp_data[store_count], dmem_wdata);
          errors++;
        end
        if (dmem_byte_en !== exp_be[store_count]) begin
          $display("mismatch at %0t: dmem_byte_en expected %h got %h",
                   $time, exp_be[store_count], dmem_byte_en);
          errors++;
        end
      end
      store_count++;
      // Only the enabled lanes change.
      for (int b = 0; b < 4; b++) begin
        if (dmem_byte_en[b]) begin
          dmem[dmem_addr[9:2]][8*b +: 8] = dmem_wdata[8*b +: 8];
        end
      end
    end
  end

  initial begin
    int                 fd;
    int                 n;
    int                 cycles;
    logic [7:0]         tag;
    word_t              a;
    word_t              d;
    logic [3:0]         be;
    logic [8*160-1:0]   line;
    bit                 done_reading;

    rst       = 1'b1;
    dmem_busy = 1'b0;
    // Unloaded instruction words halt the core.
    // Data words carry their own address.
    for (int i = 0; i < 256; i++) begin
      imem[i] = 32'h0000_0073;
      dmem[i] = 32'hC0DE_0000 | (i * 4);
    end

    fd = $fopen("tests/core_input.txt", "r");
    if (fd == 0) begin
      $display("could not open tests/core_input.txt");
      errors++;
    end else begin
      done_reading = 1'b0;
      while (!done_reading) begin
        n = $fscanf(fd, " %c", tag);
        if (n != 1) begin
          done_reading = 1'b1;
        end else begin
          case (tag)
            "#": n = $fgets(line, fd);
            "I": begin
              n = $fscanf(fd, "%h %h", a, d);
              imem[a[9:2]] = d;
            end
            "D": begin
              n = $fscanf(fd, "%h %h", a, d);
              dmem[a[9:2]] = d;
            end
            "W": begin
              n = $fscanf(fd, "%h %h %h", a, d, be);
              exp_addr.push_back(a);
              exp_data.push_back(d);
              exp_be.push_back(be);
            end
            "H": done_reading = 1'b1;
            default: begin
              $display("unknown record type in the input file");
              errors++;
              done_reading = 1'b1;
            end
          endcase
        end
      end
      $fclose(fd);
    end

    repeat (3) @(posedge CLK);
    #1 rst = 1'b0;

    // Halt must come from the ECALL at the end of the program.
    cycles = 0;
    while (halt !== 1'b1 && cycles < HALT_TIMEOUT) begin
      @(posedge CLK);
      #1;
      cycles++;
    end
    checks++;
    if (halt !== 1'b1) begin
      $display("timeout: halt did not rise within %0d cycles", HALT_TIMEOUT);
      errors++;
    end

    // A short window in which no further store may complete.
    for (int k = 0; k < 8; k++) begin
      @(posedge CLK);
    end
    #1;

    checks++;
    if (store_count != exp_addr.size()) begin
      $display("mismatch at %0t: store count expected %0d got %0d",
               $time, exp_addr.size(), store_count);
      errors++;
    end

    $display("errors %0d, checks %0d", errors, checks);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
